// ==== hw/synth_defines.svh ====
`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

// Audio sample width in bits
`define SAMPLE_W 8

// UART bit time in system clocks
`define UART_CLKS_PER_BIT 16

// Bits per I2S word, two copies of the sample
`define I2S_WORD_W 16

// Noise LFSR start value
`define LFSR_SEED 16'hACE1

// Note code after reset (A4)
`define RESET_NOTE 33

`endif

// ==== hw/synth_pkg.sv ====
`include "synth_defines.svh"

package synth_pkg;

    // Tonal waveforms, noise is a separate enable
    typedef enum logic [1:0] {
        wave_tri,
        wave_saw,
        wave_sqr
    } wave_e;

    typedef logic [`SAMPLE_W-1:0] sample_t;

    // Current voice command held by the UART decoder
    typedef struct packed {
        logic       noise_en;
        wave_e      wave;
        logic [5:0] note;
    } synth_cmd_t;

    typedef logic [17:0] period_t;

    // Clocks per sample step at octave 0, C through B
    localparam period_t semitone_periods [12] = '{
        18'd191572,  // C
        18'd180360,  // C#
        18'd170262,  // D
        18'd160714,  // D#
        18'd151516,  // E
        18'd143172,  // F
        18'd135134,  // F#
        18'd127550,  // G
        18'd120482,  // G#
        18'd113636,  // A
        18'd107526,  // A#
        18'd101734   // B
    };

endpackage

// ==== hw/uart_cmd_rx.sv ====
`timescale 1ns/1ps
`include "synth_defines.svh"

module uart_cmd_rx import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,
    input  logic       rx,
    output synth_cmd_t cmd
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;   // Clocks within the current bit
    logic [2:0]       bit_idx;   // Data bit number
    logic [7:0]       shift_q;   // Received byte, LSB first
    logic             rx_q;      // Previous line level for edge detect

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            rx_q    <= 1'b1;
            cmd     <= '{noise_en: 1'b0, wave: wave_tri, note: 6'(`RESET_NOTE)};
        end else if (ena) begin
            rx_q <= rx;
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_q && !rx) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // Re-check the start bit at its middle
                    if (bit_cnt == HALF_LAST) begin
                        bit_cnt <= '0;
                        state   <= rx ? st_idle : st_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_cnt == BIT_LAST) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    // Stop bit level is not checked
                    if (bit_cnt == BIT_LAST) begin
                        bit_cnt <= '0;
                        state   <= st_idle;
                        case (shift_q)
                            8'h4E:   cmd.noise_en <= 1'b1;    // 'N'
                            8'h46:   cmd.noise_en <= 1'b0;    // 'F'
                            8'h54:   cmd.wave     <= wave_tri; // 'T'
                            8'h53:   cmd.wave     <= wave_saw; // 'S'
                            8'h51:   cmd.wave     <= wave_sqr; // 'Q'
                            default: cmd.note     <= shift_q[5:0];
                        endcase
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data shift register, sampled at mid bit
    always_ff @(posedge clk) begin
        if (ena && state == st_data && bit_cnt == BIT_LAST) begin
            shift_q <= {rx, shift_q[7:1]};
        end
    end

endmodule

// ==== hw/note_divider.sv ====
`timescale 1ns/1ps
`include "synth_defines.svh"

module note_divider import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,
    input  logic [5:0] note,
    output logic       tick
);

    // Semitone table entry shifted down by the octave
    function automatic period_t period_of(input logic [5:0] code);
        logic [2:0] oct;
        logic [3:0] semi;
        if (code >= 6'd60) begin
            oct  = 3'd2;     // Out of range codes play A4
            semi = 4'd9;
        end else if (code >= 6'd48) begin
            oct  = 3'd4;
            semi = 4'(code - 6'd48);
        end else if (code >= 6'd36) begin
            oct  = 3'd3;
            semi = 4'(code - 6'd36);
        end else if (code >= 6'd24) begin
            oct  = 3'd2;
            semi = 4'(code - 6'd24);
        end else if (code >= 6'd12) begin
            oct  = 3'd1;
            semi = 4'(code - 6'd12);
        end else begin
            oct  = 3'd0;
            semi = code[3:0];
        end
        return semitone_periods[semi] >> oct;
    endfunction

    period_t    period_next;
    period_t    period_q;    // Period of the playing note
    period_t    cnt;         // Clocks since the last tick
    logic [5:0] note_q;
    logic       note_chg;

    assign period_next = period_of(note);
    assign note_chg    = (note != note_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            note_q   <= 6'(`RESET_NOTE);
            period_q <= period_of(6'(`RESET_NOTE));
            cnt      <= '0;
            tick     <= 1'b0;
        end else if (ena) begin
            note_q <= note;
            if (note_chg) begin
                period_q <= period_next;   // Restart on a new note
                cnt      <= '0;
                tick     <= 1'b0;
            end else if (cnt == period_q - 18'd1) begin
                cnt  <= '0;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt + 18'd1;
                tick <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/wave_osc.sv ====
`timescale 1ns/1ps
`include "synth_defines.svh"

module wave_osc import synth_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    input  logic    tick,
    input  logic    noise_en,
    input  wave_e   wave,
    output sample_t sample
);

    sample_t     saw_q;
    sample_t     sqr_q;
    sample_t     tri_q;
    logic        tri_up;     // Triangle direction
    logic [15:0] lfsr_q;
    logic        tick_q;     // Oscillators settled, update sample
    sample_t     sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saw_q  <= '0;
            sqr_q  <= '0;
            tri_q  <= '0;
            tri_up <= 1'b1;
            lfsr_q <= `LFSR_SEED;
            tick_q <= 1'b0;
        end else if (ena) begin
            tick_q <= tick;
            if (tick) begin
                saw_q <= saw_q + 1'b1;
                sqr_q <= ~sqr_q;
                // Turn at the ends without repeating them
                if (tri_up) begin
                    if (tri_q == '1) begin
                        tri_up <= 1'b0;
                        tri_q  <= tri_q - 1'b1;
                    end else begin
                        tri_q <= tri_q + 1'b1;
                    end
                end else begin
                    if (tri_q == '0) begin
                        tri_up <= 1'b1;
                        tri_q  <= tri_q + 1'b1;
                    end else begin
                        tri_q <= tri_q - 1'b1;
                    end
                end
                lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            end
        end
    end

    always_comb begin
        if (noise_en) begin
            sel = lfsr_q[15:8];      // Upper byte as noise
        end else begin
            case (wave)
                wave_saw: sel = saw_q;
                wave_sqr: sel = sqr_q;
                default:  sel = tri_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample <= '0;
        end else if (ena && tick_q) begin
            sample <= sel;
        end
    end

endmodule

// ==== hw/i2s_tx.sv ====
`timescale 1ns/1ps
`include "synth_defines.svh"

module i2s_tx import synth_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    input  sample_t sample,
    output logic    sck,
    output logic    ws,
    output logic    sd
);

    localparam int BIT_W = $clog2(`I2S_WORD_W);

    logic [BIT_W-1:0]      bit_cnt;  // Bit position within the word
    logic [`I2S_WORD_W-1:0] shift_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '1;       // First falling sck starts a word
        end else if (ena) begin
            sck <= ~sck;
            if (sck) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '1) begin
                    ws <= ~ws;
                    sd <= sample[`SAMPLE_W-1];
                end else begin
                    sd <= shift_q[`I2S_WORD_W-2];
                end
            end
        end
    end

    // Word payload, MSB goes out first
    always_ff @(posedge clk) begin
        if (ena && sck) begin
            if (bit_cnt == '1) begin
                shift_q <= {sample, sample};
            end else begin
                shift_q <= {shift_q[`I2S_WORD_W-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== hw/synth_top.sv ====
`timescale 1ns/1ps

module synth_top import synth_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic ena,
    input  logic uart_rx,
    output logic sck,
    output logic ws,
    output logic sd
);

    synth_cmd_t cmd;
    logic       tick;
    sample_t    sample;

    uart_cmd_rx uart_cmd_rx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .rx    (uart_rx),
        .cmd   (cmd)
    );

    note_divider note_divider_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .note  (cmd.note),
        .tick  (tick)
    );

    wave_osc wave_osc_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .tick     (tick),
        .noise_en (cmd.noise_en),
        .wave     (cmd.wave),
        .sample   (sample)
    );

    i2s_tx i2s_tx_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .ena    (ena),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

// ==== test/synth_chk.sv ====
`timescale 1ns/1ps

module synth_chk (
    input logic clk,
    input logic rst_n,
    input logic ena,
    input logic tick,
    input logic sck,
    input logic ws,
    input logic sd
);

    // Divider pulse is a single enabled clock wide
    tick_one_clock: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tick && ena) |=> !tick
    ) else $error("tick stayed high for two clocks");

    // Serial data and word select move only with a falling bit clock
    i2s_edge: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($changed(ws) || $changed(sd)) |-> $fell(sck)
    ) else $error("ws or sd changed away from a falling sck");

    // I2S lines idle low in reset
    reset_low: assert property (
        @(posedge clk)
        !rst_n |-> (!sck && !ws && !sd)
    ) else $error("I2S outputs not low during reset");

endmodule

// ==== test/synth_tb.sv ====
`timescale 1ns/1ps
`include "synth_defines.svh"

module synth_tb import synth_pkg::*; ();

    localparam int N_ROWS = 14;
    localparam int TOL    = 32;   // One I2S word of jitter
    localparam int K_TRI   = 0;
    localparam int K_SAW   = 1;
    localparam int K_SQR   = 2;
    localparam int K_NOISE = 3;

    // One stimulus row
    typedef struct packed {
        logic [7:0] cmd_byte;
        int         kind;      // Expected waveform
        int         period;    // Expected clocks between sample changes
        bit         is_note;
    } row_t;

    logic clk = 1'b0;
    logic rst_n;
    logic ena;
    logic uart_rx;
    logic sck;
    logic ws;
    logic sd;

    synth_top synth_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .uart_rx (uart_rx),
        .sck     (sck),
        .ws      (ws),
        .sd      (sd)
    );

    bind synth_top synth_chk synth_chk_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .tick  (tick),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    always #4 clk = ~clk;

    row_t        rows [N_ROWS];  // Stimulus table

    int          cycles = 0;
    int          limit = 32'h7fffffff;
    int          val_q[$];       // Decoded sample changes
    int          time_q[$];
    int          last_val = 0;
    int          last_time = 0;
    logic [15:0] word_sh = '0;
    int          nbits = 16;
    logic        ws_prev = 1'b0;
    logic        sck_prev = 1'b0;
    logic [15:0] lfsr_model = `LFSR_SEED;
    logic [31:0] lcg_state = 32'h9c04;
    bit          tri_up = 1'b1;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d clocks while waiting for sample changes", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic compare_val(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int period_rule(input int code);
        int c;
        c = (code >= 60) ? `RESET_NOTE : code;   // Out of range plays A4
        return int'(semitone_periods[c % 12]) >> (c / 12);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Logs the finished word when the sample moved
    task automatic record_word(input logic [15:0] w);
        compare_val("word_halves", int'(w[15:8]), int'(w[7:0]));
        if (int'(w[7:0]) != last_val) begin
            last_val = int'(w[7:0]);
            val_q.push_back(last_val);
            time_q.push_back(cycles);
        end
    endtask

    // I2S decoder, sd is read in the clock after sck rises
    always @(negedge clk) begin
        if (sck && !sck_prev) begin
            if (ws != ws_prev) begin   // A ws edge marks the MSB of a new word
                ws_prev = ws;
                word_sh = {15'd0, sd};
                nbits   = 1;
            end else if (nbits < 16) begin
                word_sh = {word_sh[14:0], sd};
                nbits   = nbits + 1;
                if (nbits == 16) begin
                    record_word(word_sh);
                end
            end
        end
        sck_prev = sck;
    end

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};   // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    // Pops the next change and infers skipped ticks from time when the note is steady
    task automatic next_change(input int period, input bit by_time,
                               output int v, output int interval);
        int t;
        int k;
        while (val_q.size() == 0) begin
            @(posedge clk);
        end
        v         = val_q.pop_front();
        t         = time_q.pop_front();
        interval  = t - last_time;
        last_time = t;
        k = by_time ? (interval + period / 2) / period : 1;
        if (k < 1) begin
            k = 1;
        end
        repeat (k) lfsr_model = lfsr_step(lfsr_model);
    endtask

    task automatic check_interval(input int interval, input int period);
        int diff;
        diff = interval - period;
        if (diff < 0) begin
            diff = -diff;
        end
        compare_val("change_interval", (diff <= TOL) ? period : interval, period);
    endtask

    function automatic int tri_next(input int p);
        if (tri_up) begin
            if (p == 255) begin
                tri_up = 1'b0;
                return 254;
            end
            return p + 1;
        end
        if (p == 0) begin
            tri_up = 1'b1;
            return 1;
        end
        return p - 1;
    endfunction

    // Command byte, expected wave, change interval, note flag
    task automatic fill_table();
        logic [5:0] code;
        rows[0] = '{8'h53, K_SAW, period_rule(`RESET_NOTE), 1'b0};   // 'S'
        rows[1] = '{8'h3B, K_SAW, period_rule(59), 1'b1};             // Code 59
        rows[2] = '{8'h51, K_SQR, period_rule(59), 1'b0};             // 'Q'
        rows[3] = '{8'h54, K_TRI, period_rule(59), 1'b0};             // 'T'
        rows[4] = '{8'h4E, K_NOISE, period_rule(59), 1'b0};           // 'N'
        rows[5] = '{8'h46, K_TRI, period_rule(59), 1'b0};             // 'F'
        for (int r = 6; r < N_ROWS; r++) begin
            lcg_state = lcg_next(lcg_state);
            code      = lcg_state[21:16];
            rows[r]   = '{{2'b00, code}, K_TRI, period_rule(int'(code)), 1'b1};
        end
    endtask

    initial begin
        int v0;
        int v;
        int p;
        int iv;
        int exp;
        int lim;
        logic s0;
        logic w0;
        logic d0;
        rst_n   = 1'b1;
        ena     = 1'b1;
        uart_rx = 1'b1;
        fill_table();
        lim = 4 * period_rule(`RESET_NOTE) + 1000 + 20000;
        for (int r = 0; r < N_ROWS; r++) begin
            lim += 6 * rows[r].period + 400;
        end
        limit = lim;
        #1 rst_n = 1'b0;

        repeat (4) begin
            @(negedge clk);
            compare_val("sck", int'(sck), 0);
            compare_val("ws", int'(ws), 0);
            compare_val("sd", int'(sd), 0);
        end
        rst_n = 1'b1;
        repeat (20) @(negedge clk);

        // Freeze test
        ena = 1'b0;
        s0 = sck;
        w0 = ws;
        d0 = sd;
        repeat (100) begin
            @(negedge clk);
            compare_val("sck", int'(sck), int'(s0));
            compare_val("ws", int'(ws), int'(w0));
            compare_val("sd", int'(sd), int'(d0));
        end
        ena = 1'b1;

        // Triangle rises from zero after reset
        for (int i = 1; i <= 3; i++) begin
            next_change(period_rule(`RESET_NOTE), 1'b0, v, iv);
            compare_val("sample", v, i);
            if (i > 1) begin
                check_interval(iv, period_rule(`RESET_NOTE));
            end
        end
        @(negedge clk);

        for (int r = 0; r < N_ROWS; r++) begin
            send_byte(rows[r].cmd_byte);
            next_change(rows[r].period, !rows[r].is_note, v0, iv);
            next_change(rows[r].period, !rows[r].is_note, v, iv);
            p = v;
            if (rows[r].kind == K_TRI) begin
                // Direction from the last two values, turning at the ends
                tri_up = (p == 0) ? 1'b1 : (p == 255) ? 1'b0 : (p > v0);
            end
            for (int i = 0; i < 3; i++) begin
                next_change(rows[r].period, !rows[r].is_note, v, iv);
                check_interval(iv, rows[r].period);
                case (rows[r].kind)
                    K_SAW:   exp = (p + 1) % 256;
                    K_SQR:   exp = (p == 0) ? 255 : 0;
                    K_NOISE: exp = int'(lfsr_model[15:8]);
                    default: exp = tri_next(p);
                endcase
                compare_val("sample", v, exp);
                p = v;
            end
            @(negedge clk);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/synth_pkg.sv
hw/uart_cmd_rx.sv
hw/note_divider.sv
hw/wave_osc.sv
hw/i2s_tx.sv
hw/synth_top.sv
test/synth_chk.sv
test/synth_tb.sv

// ==== Makefile ====
SRCS := hw/synth_defines.svh hw/synth_pkg.sv hw/uart_cmd_rx.sv hw/note_divider.sv \
        hw/wave_osc.sv hw/i2s_tx.sv hw/synth_top.sv test/synth_chk.sv test/synth_tb.sv all.f

.PHONY: run clean

run: obj_dir/Vsynth_tb
	./obj_dir/Vsynth_tb

obj_dir/Vsynth_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module synth_tb -o Vsynth_tb

clean:
	rm -rf obj_dir
